// ==== source/mipsPkg.sv ====
package mipsPkg;

    localparam int WORD_W = 32;
    localparam int REG_AW = 5;
    localparam int WEN_W  = 4;

    localparam logic [WORD_W-1:0] RESET_PC = 32'hbfc0_0000;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_AW-1:0] regIdx_t;

    // primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // funct field of OP_RTYPE
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI
    } aluOp_e;

    // encoding order matters, stage n sits at index n-1 of the hazard view
    typedef enum logic [2:0] {
        REGFILE,
        FROM_E,
        FROM_M,
        FROM_M2,
        FROM_W
    } fwdSel_e;

    typedef struct packed {
        logic [5:0] op;
        regIdx_t    rs;
        regIdx_t    rt;
        regIdx_t    rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFmt_t;

    typedef struct packed {
        logic [5:0]  op;
        regIdx_t     rs;
        regIdx_t     rt;
        logic [15:0] imm;
    } iFmt_t;

    typedef union packed {
        rFmt_t r;
        iFmt_t i;
    } instr_u;

    // what an in-flight instruction will write back
    typedef struct packed {
        logic    regWrite;
        regIdx_t writeReg;
        logic    isLoad;
    } stageWb_t;

endpackage

// ==== source/hazardBus_if.sv ====
`timescale 1ns/1ps

interface hazardBus_if import mipsPkg::*; ();

    stageWb_t wbE;
    stageWb_t wbM;
    stageWb_t wbM2;
    stageWb_t wbW;

    regIdx_t  rsD;
    regIdx_t  rtD;

    logic     stallF;
    logic     stallD;
    logic     bubbleE;
    logic     freeze;   // cache back-pressure, holds every stage

    fwdSel_e  fwdA;
    fwdSel_e  fwdB;

    modport fetch   (input stallF, freeze);
    modport decode  (output rsD, rtD, input fwdA, fwdB, stallD, bubbleE);
    modport execute (output wbE, input freeze);
    modport memory  (output wbM, wbM2, wbW, input freeze);
    modport hazard  (input wbE, wbM, wbM2, wbW, rsD, rtD,
                     output stallF, stallD, bubbleE, freeze, fwdA, fwdB);

endinterface

// ==== source/fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit import mipsPkg::*; (
    input  logic       clk,
    input  logic       arstN_i,
    input  word_t      instrF2_i,
    hazardBus_if.fetch hz,
    output word_t      pcIf1_o,
    output logic       instEn_o,
    output word_t      pcD_o,
    output word_t      instrD_o
);

    word_t pcIf2;
    logic  enIf2;   // IF2 holds a real fetch
    logic  hold;

    // load-use and freeze both keep IF1, IF2 and D where they are
    assign hold = hz.stallF | hz.freeze;

    // ram keeps its last word while disabled, so IF2 stays valid
    assign instEn_o = ~hold;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            pcIf1_o  <= RESET_PC;
            enIf2    <= 1'b0;
            instrD_o <= '0;
        end else if (!hold) begin
            pcIf1_o  <= pcIf1_o + 32'd4;
            enIf2    <= instEn_o;
            instrD_o <= instrF2_i & {WORD_W{enIf2}}; // no-op until first fetch lands
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            pcIf2 <= pcIf1_o;
            pcD_o <= pcIf2;
        end
    end

endmodule

// ==== source/regFile.sv ====
`timescale 1ns/1ps

module regFile import mipsPkg::*; (
    input  logic    clk,
    input  logic    arstN_i,
    input  regIdx_t raddrA_i,
    input  regIdx_t raddrB_i,
    input  regIdx_t waddr_i,
    input  logic    we_i,
    input  word_t   wdata_i,
    output word_t   rdataA_o,
    output word_t   rdataB_o
);

    word_t regs [1:(1 << REG_AW) - 1];  // r0 has no storage

    always_ff @(posedge clk) begin
        if (we_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdataA_o = (raddrA_i == '0) ? '0 : regs[raddrA_i];
    assign rdataB_o = (raddrB_i == '0) ? '0 : regs[raddrB_i];

    // decode drops the write flag for r0 targets, so none reaches here
    weNotR0: assert property (@(posedge clk) disable iff (!arstN_i)
        we_i |-> waddr_i != '0);

endmodule

// ==== source/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage import mipsPkg::*; (
    input  logic        clk,
    input  logic        arstN_i,
    input  word_t       pcD_i,
    input  word_t       instrD_i,
    input  word_t       aluOutE_i,
    input  word_t       resultM_i,
    input  word_t       resultM2_i,
    input  word_t       resultW_i,
    input  stageWb_t    wbW_i,
    hazardBus_if.decode hz,
    output word_t       srcAE_o,
    output word_t       srcBE_o,
    output word_t       storeDataE_o,
    output aluOp_e      aluOpE_o,
    output logic        isLoadE_o,
    output logic        isStoreE_o,
    output word_t       pcE_o,
    output stageWb_t    wbDE_o
);

    instr_u   ins;
    aluOp_e   aluOp;
    logic     isImm;
    logic     signExt;
    logic     regWrite;
    logic     isLoad;
    logic     isStore;
    logic     useShamt;   // sll takes shamt on the A side
    regIdx_t  dest;
    stageWb_t wbD;
    word_t    rfA;
    word_t    rfB;
    word_t    fwdValA;
    word_t    fwdValB;
    word_t    immExt;
    logic     advE;

    assign ins    = instrD_i;
    assign hz.rsD = ins.r.rs;
    assign hz.rtD = ins.r.rt;

    regFile u_regFile (
        .clk     (clk),
        .arstN_i (arstN_i),
        .raddrA_i(ins.r.rs),
        .raddrB_i(ins.r.rt),
        .waddr_i (wbW_i.writeReg),
        .we_i    (wbW_i.regWrite),
        .wdata_i (resultW_i),
        .rdataA_o(rfA),
        .rdataB_o(rfB)
    );

    always_comb begin
        aluOp    = ALU_ADD;
        isImm    = 1'b1;
        signExt  = 1'b1;
        regWrite = 1'b1;
        isLoad   = 1'b0;
        isStore  = 1'b0;
        useShamt = 1'b0;
        case (ins.i.op)
            OP_RTYPE: begin
                isImm = 1'b0;
                case (ins.r.funct)
                    FN_ADDU: aluOp = ALU_ADD;
                    FN_SUBU: aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_XOR:  aluOp = ALU_XOR;
                    FN_SLT:  aluOp = ALU_SLT;
                    FN_SLL: begin
                        aluOp    = ALU_SLL;
                        useShamt = 1'b1;
                    end
                    default: regWrite = 1'b0;  // unsupported funct retires silently
                endcase
            end
            OP_ADDIU: aluOp = ALU_ADD;
            OP_ANDI: begin
                aluOp   = ALU_AND;
                signExt = 1'b0;
            end
            OP_ORI: begin
                aluOp   = ALU_OR;
                signExt = 1'b0;
            end
            OP_LUI: aluOp = ALU_LUI;
            OP_LW:  isLoad = 1'b1;
            OP_SW: begin
                isStore  = 1'b1;
                regWrite = 1'b0;
            end
            default: regWrite = 1'b0;
        endcase
    end

    assign dest   = (ins.i.op == OP_RTYPE) ? ins.r.rd : ins.i.rt;
    assign immExt = signExt ? {{16{ins.i.imm[15]}}, ins.i.imm} : {16'b0, ins.i.imm};

    // writes to r0 are dropped right here
    assign wbD.regWrite = regWrite && (dest != '0);
    assign wbD.writeReg = dest;
    assign wbD.isLoad   = isLoad;

    function automatic word_t pickFwd(fwdSel_e sel, word_t fromRf);
        case (sel)
            FROM_E:  return aluOutE_i;
            FROM_M:  return resultM_i;
            FROM_M2: return resultM2_i;
            FROM_W:  return resultW_i;
            default: return fromRf;
        endcase
    endfunction

    always_comb begin
        fwdValA = pickFwd(hz.fwdA, rfA);
        fwdValB = pickFwd(hz.fwdB, rfB);
    end

    // D/E loads on a free cycle or takes the load-use bubble
    assign advE = ~hz.stallD | hz.bubbleE;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            aluOpE_o   <= ALU_ADD;
            isLoadE_o  <= 1'b0;
            isStoreE_o <= 1'b0;
            wbDE_o     <= '0;
        end else if (advE) begin
            aluOpE_o   <= aluOp;
            isLoadE_o  <= isLoad & ~hz.bubbleE;
            isStoreE_o <= isStore & ~hz.bubbleE;
            wbDE_o     <= hz.bubbleE ? '0 : wbD;
        end
    end

    always_ff @(posedge clk) begin
        if (advE) begin
            srcAE_o      <= useShamt ? {{(WORD_W - 5){1'b0}}, ins.r.shamt} : fwdValA;
            srcBE_o      <= isImm ? immExt : fwdValB;
            storeDataE_o <= fwdValB;
            pcE_o        <= pcD_i;
        end
    end

endmodule

// ==== source/executeStage.sv ====
`timescale 1ns/1ps

module executeStage import mipsPkg::*; (
    input  logic         clk,
    input  logic         arstN_i,
    input  word_t        srcAE_i,
    input  word_t        srcBE_i,
    input  word_t        storeDataE_i,
    input  aluOp_e       aluOpE_i,
    input  logic         isLoadE_i,
    input  logic         isStoreE_i,
    input  word_t        pcE_i,
    input  stageWb_t     wbDE_i,
    hazardBus_if.execute hz,
    output word_t        aluOutE_o,
    output word_t        aluOutM_o,
    output word_t        storeDataM_o,
    output logic         isLoadM_o,
    output logic         isStoreM_o,
    output word_t        pcM_o,
    output stageWb_t     wbM_o
);

    always_comb begin
        case (aluOpE_i)
            ALU_ADD: aluOutE_o = srcAE_i + srcBE_i;
            ALU_SUB: aluOutE_o = srcAE_i - srcBE_i;
            ALU_AND: aluOutE_o = srcAE_i & srcBE_i;
            ALU_OR:  aluOutE_o = srcAE_i | srcBE_i;
            ALU_XOR: aluOutE_o = srcAE_i ^ srcBE_i;
            ALU_SLT: aluOutE_o = {{(WORD_W - 1){1'b0}}, $signed(srcAE_i) < $signed(srcBE_i)};
            ALU_SLL: aluOutE_o = srcBE_i << srcAE_i[4:0];  // shamt arrives on A
            ALU_LUI: aluOutE_o = {srcBE_i[15:0], 16'b0};
            default: aluOutE_o = '0;
        endcase
    end

    assign hz.wbE = wbDE_i;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            isLoadM_o  <= 1'b0;
            isStoreM_o <= 1'b0;
            wbM_o      <= '0;
        end else if (!hz.freeze) begin
            isLoadM_o  <= isLoadE_i;
            isStoreM_o <= isStoreE_i;
            wbM_o      <= wbDE_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!hz.freeze) begin
            aluOutM_o    <= aluOutE_o;
            storeDataM_o <= storeDataE_i;
            pcM_o        <= pcE_i;
        end
    end

endmodule

// ==== source/memWriteback.sv ====
`timescale 1ns/1ps

module memWriteback import mipsPkg::*; (
    input  logic           clk,
    input  logic           arstN_i,
    input  word_t          aluOutM_i,
    input  word_t          storeDataM_i,
    input  logic           isLoadM_i,
    input  logic           isStoreM_i,
    input  word_t          pcM_i,
    input  stageWb_t       wbM_i,
    input  word_t          memRdataM2_i,
    hazardBus_if.memory    hz,
    output logic           memEn_o,
    output word_t          memAddr_o,
    output logic [3:0]     memWriteSel_o,
    output word_t          memWdata_o,
    output word_t          resultM_o,
    output word_t          resultM2_o,
    output word_t          resultW_o,
    output stageWb_t       wbW_o,
    output word_t          debugWbPc_o,
    output logic [WEN_W-1:0] debugWbRfWen_o,
    output regIdx_t        debugWbRfWnum_o,
    output word_t          debugWbRfWdata_o
);

    stageWb_t wbM2;
    logic     isLoadM2;
    word_t    aluOutM2;
    word_t    pcM2;

    // data ram request, word access only
    assign memEn_o       = isLoadM_i | isStoreM_i;
    assign memAddr_o     = aluOutM_i;
    assign memWriteSel_o = {4{isStoreM_i}};
    assign memWdata_o    = storeDataM_i;

    assign resultM_o  = aluOutM_i;  // loads never forward from M, hazard stalls them
    assign resultM2_o = isLoadM2 ? memRdataM2_i : aluOutM2;

    assign hz.wbM  = wbM_i;
    assign hz.wbM2 = wbM2;
    assign hz.wbW  = wbW_o;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            wbM2     <= '0;
            isLoadM2 <= 1'b0;
            wbW_o    <= '0;
        end else if (!hz.freeze) begin
            wbM2     <= wbM_i;
            isLoadM2 <= isLoadM_i;
            wbW_o    <= wbM2;
        end
    end

    always_ff @(posedge clk) begin
        if (!hz.freeze) begin
            aluOutM2    <= aluOutM_i;
            pcM2        <= pcM_i;
            resultW_o   <= resultM2_o;
            debugWbPc_o <= pcM2;
        end
    end

    // W is reported once, in the cycle it finally moves on
    assign debugWbRfWen_o   = {WEN_W{wbW_o.regWrite & ~hz.freeze}};
    assign debugWbRfWnum_o  = wbW_o.writeReg;
    assign debugWbRfWdata_o = resultW_o;

endmodule

// ==== source/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit import mipsPkg::*; (
    input  logic        clk,
    input  logic        arstN_i,
    input  logic        iCacheStall_i,
    input  logic        dCacheStall_i,
    hazardBus_if.hazard hz
);

    stageWb_t inFlight [4];   // E, M, M2, W
    logic     loadUse;

    assign inFlight[0] = hz.wbE;
    assign inFlight[1] = hz.wbM;
    assign inFlight[2] = hz.wbM2;
    assign inFlight[3] = hz.wbW;

    // r0 never matches, decode already cleared regWrite for it
    function automatic logic hits(stageWb_t wb, regIdx_t r);
        return wb.regWrite && (wb.writeReg == r);
    endfunction

    function automatic logic loadHit(stageWb_t wb, regIdx_t rs, regIdx_t rt);
        return wb.isLoad && (hits(wb, rs) || hits(wb, rt));
    endfunction

    // walk from W toward E so the nearest producer wins
    function automatic fwdSel_e nearest(regIdx_t r);
        fwdSel_e sel;
        sel = REGFILE;
        for (int s = 3; s >= 0; s--) begin
            if (hits(inFlight[s], r)) begin
                sel = fwdSel_e'(s + 1);
            end
        end
        return sel;
    endfunction

    // load data shows up in M2 only
    assign loadUse = loadHit(hz.wbE, hz.rsD, hz.rtD) | loadHit(hz.wbM, hz.rsD, hz.rtD);

    assign hz.freeze  = iCacheStall_i | dCacheStall_i;
    assign hz.stallF  = loadUse;
    assign hz.stallD  = loadUse | hz.freeze;
    assign hz.bubbleE = loadUse & ~hz.freeze;  // a frozen E simply holds

    always_comb begin
        hz.fwdA = nearest(hz.rsD);
        hz.fwdB = nearest(hz.rtD);
    end

    // bubble lands in E on the next edge as a non-writing slot
    bubbleIntoE: assert property (@(posedge clk) disable iff (!arstN_i)
        hz.bubbleE |=> !hz.wbE.regWrite);

    property fwdTargetNonZero(fwdSel_e sel);
        @(posedge clk) disable iff (!arstN_i)
        sel != REGFILE |-> inFlight[sel - 1].writeReg != '0;
    endproperty

    fwdANotR0: assert property (fwdTargetNonZero(hz.fwdA));
    fwdBNotR0: assert property (fwdTargetNonZero(hz.fwdB));

endmodule

// ==== source/datapath.sv ====
`timescale 1ns/1ps

module datapath import mipsPkg::*; (
    input  logic             clk,
    input  logic             arstN_i,
    // instruction ram
    output word_t            pcIf1_o,
    output logic             instEn_o,
    input  word_t            instrF2_i,
    input  logic             iCacheStall_i,
    // data ram
    output logic             memEn_o,
    output word_t            memAddr_o,
    input  word_t            memRdataM2_i,
    output logic [3:0]       memWriteSel_o,
    output word_t            memWdata_o,
    input  logic             dCacheStall_i,
    // debug writeback
    output word_t            debugWbPc_o,
    output logic [WEN_W-1:0] debugWbRfWen_o,
    output regIdx_t          debugWbRfWnum_o,
    output word_t            debugWbRfWdata_o
);

    hazardBus_if hz ();

    word_t    pcD;
    word_t    instrD;
    word_t    srcAE;
    word_t    srcBE;
    word_t    storeDataE;
    aluOp_e   aluOpE;
    logic     isLoadE;
    logic     isStoreE;
    word_t    pcE;
    stageWb_t wbDE;
    word_t    aluOutE;
    word_t    aluOutM;
    word_t    storeDataM;
    logic     isLoadM;
    logic     isStoreM;
    word_t    pcM;
    stageWb_t wbM;
    word_t    resultM;
    word_t    resultM2;
    word_t    resultW;
    stageWb_t wbW;

    fetchUnit u_fetchUnit (
        .clk      (clk),
        .arstN_i  (arstN_i),
        .instrF2_i(instrF2_i),
        .hz       (hz.fetch),
        .pcIf1_o  (pcIf1_o),
        .instEn_o (instEn_o),
        .pcD_o    (pcD),
        .instrD_o (instrD)
    );

    decodeStage u_decodeStage (
        .clk         (clk),
        .arstN_i     (arstN_i),
        .pcD_i       (pcD),
        .instrD_i    (instrD),
        .aluOutE_i   (aluOutE),
        .resultM_i   (resultM),
        .resultM2_i  (resultM2),
        .resultW_i   (resultW),
        .wbW_i       (wbW),
        .hz          (hz.decode),
        .srcAE_o     (srcAE),
        .srcBE_o     (srcBE),
        .storeDataE_o(storeDataE),
        .aluOpE_o    (aluOpE),
        .isLoadE_o   (isLoadE),
        .isStoreE_o  (isStoreE),
        .pcE_o       (pcE),
        .wbDE_o      (wbDE)
    );

    executeStage u_executeStage (
        .clk         (clk),
        .arstN_i     (arstN_i),
        .srcAE_i     (srcAE),
        .srcBE_i     (srcBE),
        .storeDataE_i(storeDataE),
        .aluOpE_i    (aluOpE),
        .isLoadE_i   (isLoadE),
        .isStoreE_i  (isStoreE),
        .pcE_i       (pcE),
        .wbDE_i      (wbDE),
        .hz          (hz.execute),
        .aluOutE_o   (aluOutE),
        .aluOutM_o   (aluOutM),
        .storeDataM_o(storeDataM),
        .isLoadM_o   (isLoadM),
        .isStoreM_o  (isStoreM),
        .pcM_o       (pcM),
        .wbM_o       (wbM)
    );

    memWriteback u_memWriteback (
        .clk             (clk),
        .arstN_i         (arstN_i),
        .aluOutM_i       (aluOutM),
        .storeDataM_i    (storeDataM),
        .isLoadM_i       (isLoadM),
        .isStoreM_i      (isStoreM),
        .pcM_i           (pcM),
        .wbM_i           (wbM),
        .memRdataM2_i    (memRdataM2_i),
        .hz              (hz.memory),
        .memEn_o         (memEn_o),
        .memAddr_o       (memAddr_o),
        .memWriteSel_o   (memWriteSel_o),
        .memWdata_o      (memWdata_o),
        .resultM_o       (resultM),
        .resultM2_o      (resultM2),
        .resultW_o       (resultW),
        .wbW_o           (wbW),
        .debugWbPc_o     (debugWbPc_o),
        .debugWbRfWen_o  (debugWbRfWen_o),
        .debugWbRfWnum_o (debugWbRfWnum_o),
        .debugWbRfWdata_o(debugWbRfWdata_o)
    );

    hazardUnit u_hazardUnit (
        .clk          (clk),
        .arstN_i      (arstN_i),
        .iCacheStall_i(iCacheStall_i),
        .dCacheStall_i(dCacheStall_i),
        .hz           (hz.hazard)
    );

endmodule

// ==== sim/tbDatapath.sv ====
`timescale 1ns/1ps

module tbDatapath import mipsPkg::*; ();

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 10;
    localparam int PROG_LEN        = 40;
    localparam int DMEM_WORDS      = 64;
    localparam int DRAIN_CYCLES    = 8;
    // two passes over the program, each with reset and drain
    localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + (PROG_LEN + 20) * 4 + DRAIN_CYCLES);
    localparam logic [31:0] SEED   = 32'd95;

    logic             clk           = 1'b0;
    logic             arstN_i       = 1'b1;
    word_t            instrF2_i     = '0;
    logic             iCacheStall_i = 1'b0;
    word_t            memRdataM2_i  = '0;
    logic             dCacheStall_i = 1'b0;
    word_t            pcIf1_o;
    logic             instEn_o;
    logic             memEn_o;
    word_t            memAddr_o;
    logic [3:0]       memWriteSel_o;
    word_t            memWdata_o;
    word_t            debugWbPc_o;
    logic [WEN_W-1:0] debugWbRfWen_o;
    regIdx_t          debugWbRfWnum_o;
    word_t            debugWbRfWdata_o;

    word_t   prog [PROG_LEN];
    word_t   dmem [DMEM_WORDS];
    word_t   modelMem [DMEM_WORDS];
    word_t   iWord = '0;      // instruction ram output register
    word_t   dWord = '0;      // data ram output register
    word_t   expPc [PROG_LEN];
    regIdx_t expReg [PROG_LEN];
    word_t   expData [PROG_LEN];
    word_t   expStAddr [PROG_LEN];
    word_t   expStData [PROG_LEN];
    int      nExp = 0;
    int      nSt = 0;
    int      retIdx;
    int      stIdx;
    int      errReset = 0;
    int      errRetire = 0;
    int      errStore = 0;
    int      errStall = 0;
    int      errEnd = 0;
    logic [31:0] rnd;
    logic    frozen;

    assign frozen = iCacheStall_i | dCacheStall_i;

    datapath i_datapath (
        .clk             (clk),
        .arstN_i         (arstN_i),
        .pcIf1_o         (pcIf1_o),
        .instEn_o        (instEn_o),
        .instrF2_i       (instrF2_i),
        .iCacheStall_i   (iCacheStall_i),
        .memEn_o         (memEn_o),
        .memAddr_o       (memAddr_o),
        .memRdataM2_i    (memRdataM2_i),
        .memWriteSel_o   (memWriteSel_o),
        .memWdata_o      (memWdata_o),
        .dCacheStall_i   (dCacheStall_i),
        .debugWbPc_o     (debugWbPc_o),
        .debugWbRfWen_o  (debugWbRfWen_o),
        .debugWbRfWnum_o (debugWbRfWnum_o),
        .debugWbRfWdata_o(debugWbRfWdata_o)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t rIns(logic [5:0] funct, int rd, int rs, int rt, int sh);
        return {OP_RTYPE, regIdx_t'(rs), regIdx_t'(rt), regIdx_t'(rd), 5'(sh), funct};
    endfunction

    function automatic word_t iIns(logic [5:0] op, int rt, int rs, int imm);
        return {op, regIdx_t'(rs), regIdx_t'(rt), 16'(imm)};
    endfunction

    // every address bit of the index shows up in the pattern
    function automatic word_t fillWord(int i);
        return 32'hc0de_0000 ^ (word_t'(i) * 32'h0101_0107);
    endfunction

    function automatic word_t fetchWord(word_t addr);
        word_t off;
        off = (addr - RESET_PC) >> 2;
        return (off < PROG_LEN) ? prog[off] : '0;  // past the end reads as sll r0
    endfunction

    task automatic loadProgram();
        foreach (prog[k]) prog[k] = '0;
        prog[0]  = iIns(OP_ADDIU, 1, 0, 'h1234);
        prog[1]  = iIns(OP_ADDIU, 2, 0, -5);
        prog[2]  = rIns(FN_ADDU, 3, 1, 2, 0);    // E and M forwards
        prog[3]  = rIns(FN_SUBU, 4, 3, 1, 0);    // E and M2
        prog[4]  = rIns(FN_XOR, 5, 4, 2, 0);
        prog[5]  = rIns(FN_OR, 6, 1, 3, 0);      // r1 from the register file
        prog[6]  = rIns(FN_SLT, 7, 2, 1, 0);
        prog[7]  = rIns(FN_SLT, 8, 1, 2, 0);
        prog[8]  = rIns(FN_SLL, 9, 0, 7, 4);
        prog[9]  = rIns(FN_AND, 11, 9, 5, 0);
        prog[10] = iIns(OP_ANDI, 12, 2, 'h00ff);
        prog[11] = iIns(OP_ORI, 13, 12, 'h8000);
        prog[12] = iIns(OP_LUI, 14, 0, 'hdead);
        prog[13] = iIns(OP_ORI, 14, 14, 'hbeef);
        prog[14] = iIns(OP_ADDIU, 10, 0, 'h40);  // data base
        prog[15] = iIns(OP_SW, 14, 10, 0);
        prog[16] = iIns(OP_SW, 13, 10, 4);
        prog[17] = iIns(OP_LW, 15, 10, 0);
        prog[18] = rIns(FN_ADDU, 16, 15, 1, 0);  // load-use at distance 1
        prog[19] = iIns(OP_LW, 17, 10, 4);
        prog[20] = iIns(OP_ADDIU, 18, 0, 7);
        prog[21] = rIns(FN_XOR, 19, 17, 18, 0);  // load-use at distance 2
        prog[22] = iIns(OP_LW, 20, 10, 8);       // untouched fill word
        prog[23] = rIns(FN_ADDU, 0, 1, 2, 0);    // r0 target, never reported
        prog[24] = 32'hfc00_0000;                // unknown opcode
        prog[25] = rIns(FN_SUBU, 21, 20, 19, 0); // load via M2, r19 via W
        prog[26] = rIns(6'h3f, 22, 1, 2, 0);     // unknown funct
        prog[27] = iIns(OP_SW, 21, 10, 12);
        prog[28] = iIns(OP_SW, 16, 10, -4);
        prog[29] = iIns(OP_LW, 23, 10, 12);
        prog[30] = rIns(FN_ADDU, 24, 23, 23, 0);
        prog[31] = rIns(FN_SLL, 25, 0, 24, 31);
        prog[32] = iIns(OP_ADDIU, 26, 25, 1);
        prog[33] = rIns(FN_OR, 27, 26, 0, 0);
        prog[34] = iIns(OP_LUI, 28, 0, 'h8000);
        prog[35] = rIns(FN_SLT, 29, 28, 27, 0);
        prog[36] = rIns(FN_ADDU, 30, 29, 21, 0);
        prog[37] = rIns(FN_ADDU, 31, 30, 14, 0); // last write, all stores before it
    endtask

    // sequential MIPS semantics, no pipeline
    task automatic runModel();
        word_t       regs [32];
        word_t       a;
        word_t       b;
        word_t       val;
        word_t       sext;
        logic [5:0]  op;
        logic [5:0]  funct;
        regIdx_t     rs;
        regIdx_t     rt;
        regIdx_t     rd;
        regIdx_t     dst;
        logic [4:0]  sh;
        logic [15:0] imm;
        logic        wr;
        foreach (regs[r]) regs[r] = '0;
        foreach (modelMem[i]) modelMem[i] = fillWord(i);
        for (int k = 0; k < PROG_LEN; k++) begin
            {op, rs, rt, rd, sh, funct} = prog[k];
            imm  = prog[k][15:0];
            sext = {{16{imm[15]}}, imm};
            a    = regs[rs];
            b    = regs[rt];
            wr   = 1'b1;
            dst  = rt;
            val  = '0;
            case (op)
                OP_RTYPE: begin
                    dst = rd;
                    case (funct)
                        FN_ADDU: val = a + b;
                        FN_SUBU: val = a - b;
                        FN_AND:  val = a & b;
                        FN_OR:   val = a | b;
                        FN_XOR:  val = a ^ b;
                        FN_SLT:  val = {31'b0, $signed(a) < $signed(b)};
                        FN_SLL:  val = b << sh;
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: val = a + sext;
                OP_ANDI:  val = a & {16'h0, imm};
                OP_ORI:   val = a | {16'h0, imm};
                OP_LUI:   val = {imm, 16'h0};
                OP_LW:    val = modelMem[(a + sext) >> 2 & 32'h3f];
                OP_SW: begin
                    wr = 1'b0;
                    modelMem[(a + sext) >> 2 & 32'h3f] = b;
                    expStAddr[nSt] = a + sext;
                    expStData[nSt] = b;
                    nSt++;
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != '0) begin
                regs[dst]     = val;
                expPc[nExp]   = RESET_PC + (word_t'(k) << 2);
                expReg[nExp]  = dst;
                expData[nExp] = val;
                nExp++;
            end
        end
    endtask

    // both rams sample at the edge and hold their output while frozen
    always @(posedge clk) begin
        if (instEn_o) begin
            iWord <= fetchWord(pcIf1_o);
        end
        if (!arstN_i) begin
            foreach (dmem[i]) dmem[i] <= fillWord(i);
        end else if (memEn_o && !frozen) begin
            if (memWriteSel_o == 4'hf) begin
                dmem[memAddr_o[7:2]] <= memWdata_o;
            end else begin
                dWord <= dmem[memAddr_o[7:2]];
            end
        end
    end

    always @(negedge clk) begin
        instrF2_i    <= iWord;
        memRdataM2_i <= dWord;
    end

    // scoreboard positions
    always @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            retIdx <= 0;
            stIdx  <= 0;
        end else begin
            if (debugWbRfWen_o != '0) retIdx <= retIdx + 1;
            if (memWriteSel_o != 4'h0 && !frozen) stIdx <= stIdx + 1;
        end
    end

    resetQuiet: assert property (@(posedge clk)
        (!arstN_i || $rose(arstN_i)) |-> debugWbRfWen_o == '0 && !memEn_o
            && memWriteSel_o == 4'h0 && pcIf1_o == RESET_PC)
    else begin
        errReset++;
        $display("CHECK FAILED at %0t: outputs not idle around reset, pc %h", $time, pcIf1_o);
    end

    retireMatch: assert property (@(posedge clk) disable iff (!arstN_i)
        debugWbRfWen_o != '0 |-> retIdx < nExp && debugWbRfWen_o == {WEN_W{1'b1}}
            && debugWbPc_o == expPc[retIdx] && debugWbRfWnum_o == expReg[retIdx]
            && debugWbRfWdata_o == expData[retIdx])
    else begin
        errRetire++;
        $display("CHECK FAILED at %0t: write %0d got pc %h r%0d = %h, expected pc %h r%0d = %h",
                 $time, retIdx, debugWbPc_o, debugWbRfWnum_o, debugWbRfWdata_o,
                 expPc[retIdx], expReg[retIdx], expData[retIdx]);
    end

    storeMatch: assert property (@(posedge clk) disable iff (!arstN_i)
        memWriteSel_o != 4'h0 |-> stIdx < nSt && memWriteSel_o == 4'hf && memEn_o
            && memAddr_o == expStAddr[stIdx] && memWdata_o == expStData[stIdx])
    else begin
        errStore++;
        $display("CHECK FAILED at %0t: store %0d got [%h] = %h sel %b, expected [%h] = %h",
                 $time, stIdx, memAddr_o, memWdata_o, memWriteSel_o,
                 expStAddr[stIdx], expStData[stIdx]);
    end

    stallQuiet: assert property (@(posedge clk) disable iff (!arstN_i)
        frozen |-> debugWbRfWen_o == '0)
    else begin
        errStall++;
        $display("CHECK FAILED at %0t: write enable %h during a cache stall",
                 $time, debugWbRfWen_o);
    end

    task automatic checkFinalState();
        assert (retIdx == nExp) else begin
            errEnd++;
            $display("CHECK FAILED at %0t: %0d writes retired, %0d expected", $time, retIdx, nExp);
        end
        assert (stIdx == nSt) else begin
            errEnd++;
            $display("CHECK FAILED at %0t: %0d stores seen, %0d expected", $time, stIdx, nSt);
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            assert (dmem[i] == modelMem[i]) else begin
                errEnd++;
                $display("CHECK FAILED at %0t: data word %0d is %h, expected %h",
                         $time, i, dmem[i], modelMem[i]);
            end
        end
    endtask

    task automatic runProgram(input logic withStalls);
        arstN_i       = 1'b0;
        @(negedge clk);
        iCacheStall_i = 1'b0;
        dCacheStall_i = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        arstN_i = 1'b1;
        while (retIdx < nExp) begin
            @(negedge clk);
            if (withStalls) begin
                rnd           = xorshift(rnd);
                iCacheStall_i = (rnd[2:0] == 3'd0);  // roughly one cycle in four overall
                dCacheStall_i = (rnd[5:3] == 3'd0);
            end
        end
        iCacheStall_i = 1'b0;
        dCacheStall_i = 1'b0;
        repeat (DRAIN_CYCLES) @(negedge clk);
        checkFinalState();
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the program did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int total;
        rnd = SEED;
        loadProgram();
        runModel();
        runProgram(1'b0);
        runProgram(1'b1);   // same expected list under random cache stalls
        total = errReset + errRetire + errStore + errStall + errEnd;
        $display("error counts: reset %0d, retire %0d, store %0d, stall %0d, final %0d",
                 errReset, errRetire, errStore, errStall, errEnd);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
source/mipsPkg.sv
source/hazardBus_if.sv
source/fetchUnit.sv
source/regFile.sv
source/decodeStage.sv
source/executeStage.sv
source/memWriteback.sv
source/hazardUnit.sv
source/datapath.sv
sim/tbDatapath.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tbDatapath -o simDatapath \
    && ./obj_dir/simDatapath | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
    || exit 1
